//--- common/disp_pkg.sv
package disp_pkg;

  ////////////////////////////////////////////////////////////
  // Frame geometry
  ////////////////////////////////////////////////////////////

  // 64 rows of 64 pixels
  localparam int FRAME_ROWS = 64;
  localparam int ROW_BITS   = 64;
  localparam int ADDR_BITS  = 6;

  // Glyph grid, four bands of four 16x16 slots
  localparam int GLYPH_SIZE = 16;
  localparam int SLOTS      = 4;
  localparam int BANDS      = 4;

  // Readout pages of eight rows
  localparam int PAGE_ROWS = 8;
  localparam int PAGES     = 8;

  ////////////////////////////////////////////////////////////
  // Glyph bitmaps
  ////////////////////////////////////////////////////////////

  // Row 0 in the top 16 bits, MSB is leftmost pixel
  localparam logic [GLYPH_SIZE*GLYPH_SIZE-1:0] GLYPH_SMILE =
    256'h0000_07E0_0810_1008_2004_4002_581A_581A_581A_4002_4422_43C2_4002_4002_300C_0FF0;

  // GAME letters
  localparam logic [GLYPH_SIZE*GLYPH_SIZE-1:0] GLYPH_G =
    256'h0000_0FF0_1008_2004_2004_2000_2000_2000_21FC_2004_2004_2004_2004_2008_1FF0_0000;
  localparam logic [GLYPH_SIZE*GLYPH_SIZE-1:0] GLYPH_A =
    256'h0000_0FF0_1008_2004_2004_2004_2004_2004_3FFC_2004_2004_2004_2004_2004_2004_0000;
  localparam logic [GLYPH_SIZE*GLYPH_SIZE-1:0] GLYPH_M =
    256'h0000_0C10_1418_2224_2364_2144_2144_2144_2084_2084_2084_2084_2084_2084_2084_0000;
  localparam logic [GLYPH_SIZE*GLYPH_SIZE-1:0] GLYPH_E =
    256'h0000_3FFC_2000_2000_2000_2000_2000_3FFC_2000_2000_2000_2000_2000_2000_3FFC_0000;

  // OVER letters, E is shared with GAME
  localparam logic [GLYPH_SIZE*GLYPH_SIZE-1:0] GLYPH_O =
    256'h0000_1FF8_2004_2004_2004_2004_2004_2004_2004_2004_2004_2004_2004_2004_1FF8_0000;
  localparam logic [GLYPH_SIZE*GLYPH_SIZE-1:0] GLYPH_V =
    256'h0000_0000_2004_2004_2004_1008_1008_1008_0810_0810_0810_0420_0420_0420_0180_0000;
  localparam logic [GLYPH_SIZE*GLYPH_SIZE-1:0] GLYPH_R =
    256'h0000_3FF8_2004_2004_2004_2004_2004_3FF8_2200_2100_2080_2040_2020_2010_200C_0000;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef logic [ADDR_BITS-1:0] row_addr_t;
  typedef logic [ROW_BITS-1:0] row_t;

  // Column within a page, 0 is the row MSB
  typedef logic [$clog2(ROW_BITS)-1:0] col_t;

  // Render, fetch page, stream page
  typedef enum logic [1:0] {
    IDLE,
    WRITE,
    GETDATA,
    TRANSDATA
  } seq_state_t;

  // RAM port bundle
  typedef struct packed {
    logic      we;
    row_addr_t addr;
    row_t      wdata;
  } ram_req_t;

endpackage

//--- rtl/frame_ram.sv
module frame_ram (
  input  logic               clk,
  input  disp_pkg::ram_req_t req,
  output disp_pkg::row_t     rdata
);

  // One word per frame row
  disp_pkg::row_t mem [disp_pkg::FRAME_ROWS];

  // Single port
  // read data registered, one cycle behind the address
  always_ff @(posedge clk)
  begin
    if (req.we)
      mem[req.addr] <= req.wdata;
    // Old word returned on a write cycle
    rdata <= mem[req.addr];
  end

endmodule

//--- frame_render/frame_composer.sv
module frame_composer (
  input  logic [3:0]          key,
  input  logic                finish,
  input  disp_pkg::row_addr_t row_addr,
  output disp_pkg::row_t      row
);

  // Lit slot per band, one hot over the whole grid
  logic [disp_pkg::BANDS-1:0][disp_pkg::SLOTS-1:0] smile_map;
  // Slot 0 lands in the row MSBs
  logic [0:disp_pkg::SLOTS-1][disp_pkg::GLYPH_SIZE-1:0] slot_px;
  logic [1:0] band;
  logic [3:0] glyph_line;

  // One 16-pixel line of a bitmap, line 0 at the top
  function automatic logic [disp_pkg::GLYPH_SIZE-1:0] glyph_row(
    input logic [disp_pkg::GLYPH_SIZE*disp_pkg::GLYPH_SIZE-1:0] bmp,
    input logic [3:0] line
  );
    glyph_row = bmp[(disp_pkg::GLYPH_SIZE - 1 - line) * disp_pkg::GLYPH_SIZE +: 16];
  endfunction

  // Band and line within band
  assign band       = 2'(row_addr / disp_pkg::GLYPH_SIZE);
  assign glyph_line = 4'(row_addr % disp_pkg::GLYPH_SIZE);

  ////////////////////////////////////////////////////////////
  // Keypad table
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    smile_map = '0;
    case (key)
      // Top band
      4'hF: smile_map[0][0] = 1'b1;
      4'hE: smile_map[0][1] = 1'b1;
      4'hD: smile_map[0][2] = 1'b1;
      4'hC: smile_map[0][3] = 1'b1;
      4'hB: smile_map[1][0] = 1'b1;
      4'h3: smile_map[1][1] = 1'b1;
      4'h6: smile_map[1][2] = 1'b1;
      4'h9: smile_map[1][3] = 1'b1;
      4'hA: smile_map[2][0] = 1'b1;
      4'h2: smile_map[2][1] = 1'b1;
      4'h5: smile_map[2][2] = 1'b1;
      4'h8: smile_map[2][3] = 1'b1;
      // Bottom band
      4'h0: smile_map[3][0] = 1'b1;
      4'h1: smile_map[3][1] = 1'b1;
      4'h4: smile_map[3][2] = 1'b1;
      default: smile_map[3][3] = 1'b1;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Row assembly
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    slot_px = '0;
    if (finish)
    begin
      // GAME on band 1, OVER on band 2, rest blank
      if (band == 2'd1)
      begin
        slot_px[0] = glyph_row(disp_pkg::GLYPH_G, glyph_line);
        slot_px[1] = glyph_row(disp_pkg::GLYPH_A, glyph_line);
        slot_px[2] = glyph_row(disp_pkg::GLYPH_M, glyph_line);
        slot_px[3] = glyph_row(disp_pkg::GLYPH_E, glyph_line);
      end
      else if (band == 2'd2)
      begin
        slot_px[0] = glyph_row(disp_pkg::GLYPH_O, glyph_line);
        slot_px[1] = glyph_row(disp_pkg::GLYPH_V, glyph_line);
        slot_px[2] = glyph_row(disp_pkg::GLYPH_E, glyph_line);
        slot_px[3] = glyph_row(disp_pkg::GLYPH_R, glyph_line);
      end
    end
    else
    begin
      for (int s = 0; s < disp_pkg::SLOTS; s++)
        if (smile_map[band][s])
          slot_px[s] = glyph_row(disp_pkg::GLYPH_SMILE, glyph_line);
    end
  end

  assign row = slot_px;

endmodule

//--- rtl/page_transposer.sv
module page_transposer (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           load,
  input  logic [2:0]     slot,
  input  disp_pkg::row_t rdata,
  input  logic           shift,
  output logic           page_full,
  output logic           page_done,
  output logic [7:0]     data_out,
  output logic           data_valid
);

  // Eight rows of the current page, 512 bits
  disp_pkg::row_t page_buf [disp_pkg::PAGE_ROWS];
  disp_pkg::col_t col_cnt;
  disp_pkg::col_t bit_idx;
  logic [7:0]     col_byte;

  // Column 0 is the leftmost pixel, row MSB
  assign bit_idx = disp_pkg::col_t'(disp_pkg::ROW_BITS - 1) - col_cnt;

  // Last column accepted this cycle
  assign page_done = shift && (col_cnt == disp_pkg::col_t'(disp_pkg::ROW_BITS - 1));

  // Bit k from page row k
  always_comb
  begin
    for (int k = 0; k < disp_pkg::PAGE_ROWS; k++)
      col_byte[k] = page_buf[k][bit_idx];
  end

  // Page capture
  always_ff @(posedge clk)
  begin
    if (load)
      page_buf[slot] <= rdata;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      page_full  <= 1'b0;
      col_cnt    <= '0;
      data_out   <= 8'd0;
      data_valid <= 1'b0;
    end
    else
    begin
      // Full once the last slot lands, empty after column 63
      if (load && slot == 3'(disp_pkg::PAGE_ROWS - 1))
        page_full <= 1'b1;
      else if (page_done)
        page_full <= 1'b0;
      // Wraps to 0 at page end
      if (shift)
        col_cnt <= col_cnt + 1'b1;
      if (shift)
        data_out <= col_byte;
      data_valid <= shift;
    end
  end

endmodule

//--- rtl/scan_sequencer.sv
module scan_sequencer (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                change,
  input  logic                en,
  input  logic                page_full,
  input  logic                page_done,
  output disp_pkg::ram_req_t  req,
  output disp_pkg::row_addr_t row_addr,
  output logic                load,
  output logic [2:0]          slot,
  output logic                shift
);

  disp_pkg::seq_state_t state;
  disp_pkg::seq_state_t state_next;
  logic                 render_pending;
  logic                 fetch_done;
  logic                 rd_issue;
  logic                 last_row;
  logic [2:0]           page_idx;

  assign last_row = row_addr == disp_pkg::row_addr_t'(disp_pkg::FRAME_ROWS - 1);

  // Page reads until eight are out
  assign rd_issue = (state == disp_pkg::GETDATA) && !fetch_done;

  // Streaming strobe only while a page is out
  assign shift = (state == disp_pkg::TRANSDATA) && en;

  // RAM port, write data merged at top level
  always_comb
  begin
    req.we    = (state == disp_pkg::WRITE);
    req.addr  = row_addr;
    req.wdata = '0;
  end

  ////////////////////////////////////////////////////////////
  // State transitions
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    state_next = state;
    case (state)
      // Frame boundary
      disp_pkg::IDLE:
        state_next = render_pending ? disp_pkg::WRITE : disp_pkg::GETDATA;
      disp_pkg::WRITE:
        if (last_row)
          state_next = disp_pkg::GETDATA;
      disp_pkg::GETDATA:
        if (page_full)
          state_next = disp_pkg::TRANSDATA;
      disp_pkg::TRANSDATA:
        if (page_done)
          state_next = (page_idx == 3'(disp_pkg::PAGES - 1)) ? disp_pkg::IDLE
                                                               : disp_pkg::GETDATA;
      default:
        state_next = disp_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state          <= disp_pkg::IDLE;
      row_addr       <= '0;
      render_pending <= 1'b1;
      fetch_done     <= 1'b0;
      page_idx       <= '0;
      load           <= 1'b0;
      slot           <= '0;
    end
    else
    begin
      state <= state_next;
      // Sticky request, consumed at the frame boundary
      if (change)
        render_pending <= 1'b1;
      else if (state == disp_pkg::IDLE)
        render_pending <= 1'b0;
      // Row counter wraps to 0 at frame end
      if (state == disp_pkg::WRITE || rd_issue)
        row_addr <= row_addr + 1'b1;
      if (rd_issue && row_addr[2:0] == 3'd7)
        fetch_done <= 1'b1;
      else if (page_done)
        fetch_done <= 1'b0;
      if (page_done)
        page_idx <= page_idx + 1'b1;
      // Load lags the read by one cycle to meet rdata
      load <= rd_issue;
      slot <= row_addr[2:0];
    end
  end

endmodule

//--- rtl/display_ram_ctrl.sv
module display_ram_ctrl (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [3:0] key,
  input  logic       finish,
  input  logic       change,
  input  logic       en,
  output logic [7:0] data_out,
  output logic       data_valid
);

  disp_pkg::ram_req_t  seq_req;
  disp_pkg::ram_req_t  ram_req;
  disp_pkg::row_addr_t row_addr;
  disp_pkg::row_t      comp_row;
  disp_pkg::row_t      rdata;
  logic                load;
  logic [2:0]          slot;
  logic                shift;
  logic                page_full;
  logic                page_done;

  // Control and row address
  scan_sequencer i_scan_sequencer (
    .clk       (clk),
    .rst_n     (rst_n),
    .change    (change),
    .en        (en),
    .page_full (page_full),
    .page_done (page_done),
    .req       (seq_req),
    .row_addr  (row_addr),
    .load      (load),
    .slot      (slot),
    .shift     (shift)
  );

  // Pixel row for the current write address
  frame_composer i_frame_composer (
    .key      (key),
    .finish   (finish),
    .row_addr (row_addr),
    .row      (comp_row)
  );

  // Composer row rides in the sequencer's request
  always_comb
  begin
    ram_req       = seq_req;
    ram_req.wdata = comp_row;
  end

  frame_ram i_frame_ram (
    .clk   (clk),
    .req   (ram_req),
    .rdata (rdata)
  );

  // Page to column bytes
  page_transposer i_page_transposer (
    .clk        (clk),
    .rst_n      (rst_n),
    .load       (load),
    .slot       (slot),
    .rdata      (rdata),
    .shift      (shift),
    .page_full  (page_full),
    .page_done  (page_done),
    .data_out   (data_out),
    .data_valid (data_valid)
  );

endmodule

//--- tb/tb_clock_gen.sv
module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD  = 4;
  localparam int RESET_CYCLES = 8;

  // Free-running clock, period 8
  initial
  begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Reset over 8 rising edges, released on a falling edge
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

//--- tb/tb_display_ram_ctrl.sv
module tb_display_ram_ctrl;

  // One frame is 8 pages of 64 column bytes
  localparam int FRAME_BYTES  = disp_pkg::PAGES * disp_pkg::ROW_BITS;
  // Write, then per page a fetch of up to 10 cycles and 64 bytes
  localparam int FRAME_CYCLES = disp_pkg::FRAME_ROWS + 2
                                + disp_pkg::PAGES * (disp_pkg::PAGE_ROWS + 2 + disp_pkg::ROW_BITS);
  localparam int RESET_CYCLES = 8;
  // Six full-rate frames plus a throttled one counted twice, then doubled
  localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + 8 * FRAME_CYCLES);
  localparam int BYTE_TIMEOUT    = FRAME_CYCLES;

  // Keypad layout with band 0 slot 0 in the top nibble
  localparam logic [63:0] KEYPAD = {4'hF, 4'hE, 4'hD, 4'hC,
                                    4'hB, 4'h3, 4'h6, 4'h9,
                                    4'hA, 4'h2, 4'h5, 4'h8,
                                    4'h0, 4'h1, 4'h4, 4'h7};

  logic       clk;
  logic       rst_n;
  logic [3:0] key;
  logic       finish;
  logic       change;
  logic       en;
  logic [7:0] data_out;
  logic       data_valid;

  int          error_count;
  int          check_count;
  logic [31:0] lcg_state;
  logic [7:0]  got_frame[$];

  tb_clock_gen i_tb_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  display_ram_ctrl i_display_ram_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .key        (key),
    .finish     (finish),
    .change     (change),
    .en         (en),
    .data_out   (data_out),
    .data_valid (data_valid)
  );

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Line 0 is the top 16 bits of the bitmap
  function automatic logic [15:0] bitmap_line(input logic [255:0] bmp, input int line);
    return 16'(bmp >> (16 * (15 - line)));
  endfunction

  // Bitmap shown in one slot of one band
  function automatic logic [255:0] slot_glyph(input logic [3:0] k, input logic fin,
                                              input int band, input int slot);
    logic [255:0] g;
    g = '0;
    if (fin)
    begin
      // GAME on band 1, OVER on band 2
      if (band == 1)
        g = (slot == 0) ? disp_pkg::GLYPH_G : (slot == 1) ? disp_pkg::GLYPH_A :
            (slot == 2) ? disp_pkg::GLYPH_M : disp_pkg::GLYPH_E;
      else if (band == 2)
        g = (slot == 0) ? disp_pkg::GLYPH_O : (slot == 1) ? disp_pkg::GLYPH_V :
            (slot == 2) ? disp_pkg::GLYPH_E : disp_pkg::GLYPH_R;
    end
    else if (4'(KEYPAD >> (4 * (15 - (4 * band + slot)))) == k)
      g = disp_pkg::GLYPH_SMILE;
    return g;
  endfunction

  // Slot 0 shifted in first so it ends up in the MSBs
  function automatic logic [63:0] model_row(input logic [3:0] k, input logic fin, input int r);
    logic [63:0] row;
    row = '0;
    for (int s = 0; s < 4; s++)
      row = (row << 16) | 64'(bitmap_line(slot_glyph(k, fin, r / 16, s), r % 16));
    return row;
  endfunction

  // Byte idx of the stream with bit k from row 8p+k at pixel column c
  function automatic logic [7:0] model_byte(input logic [3:0] k, input logic fin, input int idx);
    logic [63:0] row;
    logic [7:0]  b;
    int          p;
    int          c;
    b = '0;
    p = idx / 64;
    c = idx % 64;
    for (int i = 0; i < 8; i++)
    begin
      row = model_row(k, fin, 8 * p + i);
      b = {1'(row >> (63 - c)), b[7:1]};
    end
    return b;
  endfunction

  ////////////////////////////////////////////////////////////
  // Checker and byte collector
  ////////////////////////////////////////////////////////////

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] expected);
    check_count++;
    if (got !== expected)
    begin
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, expected);
      error_count++;
    end
  endtask

  // Gather one frame with en held high or taken from the LCG
  task automatic collect_frame(input bit random_en);
    int idle;
    idle = 0;
    got_frame.delete();
    while (got_frame.size() < FRAME_BYTES && idle < BYTE_TIMEOUT)
    begin
      @(negedge clk);
      if (data_valid)
      begin
        // Byte must follow a cycle with en high
        if (!en)
        begin
          $display("** Error: data_valid = 0x1 after en = 0x0");
          error_count++;
        end
        got_frame.push_back(data_out);
        idle = 0;
      end
      else
        idle++;
      if (got_frame.size() >= FRAME_BYTES)
        en = 1'b0;
      else if (random_en)
      begin
        lcg_state = lcg_step(lcg_state);
        en = lcg_state[16];
      end
      else
        en = 1'b1;
    end
    en = 1'b0;
    if (got_frame.size() < FRAME_BYTES)
    begin
      $display("Frame stalled: only %0d of %0d bytes arrived", got_frame.size(), FRAME_BYTES);
      error_count++;
    end
  endtask

  task automatic compare_to_model(input logic [3:0] k, input logic fin);
    for (int i = 0; i < got_frame.size(); i++)
      check($sformatf("data_out[%0d]", i), 64'(got_frame[i]), 64'(model_byte(k, fin, i)));
  endtask

  task automatic pulse_change();
    @(negedge clk);
    change = 1'b1;
    @(negedge clk);
    change = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    @(negedge clk);
    check("data_valid", 64'(data_valid), 64'd0);
    check("data_out", 64'(data_out), 64'd0);
    @(posedge rst_n);
    // Still quiet with en low after release
    repeat (2)
    begin
      @(negedge clk);
      check("data_valid", 64'(data_valid), 64'd0);
      check("data_out", 64'(data_out), 64'd0);
    end
  endtask

  // Smiley at band 0 slot 0
  task automatic test_first_frame();
    collect_frame(1'b0);
    compare_to_model(4'hF, 1'b0);
  endtask

  // New key without change keeps the key F frame in RAM
  task automatic test_repeat_frame();
    @(negedge clk);
    key = 4'h7;
    collect_frame(1'b0);
    compare_to_model(4'hF, 1'b0);
  endtask

  // Smiley moves to band 3 slot 3
  task automatic test_rerender();
    pulse_change();
    collect_frame(1'b0);
    collect_frame(1'b0);
    compare_to_model(4'h7, 1'b0);
  endtask

  task automatic test_finish_mode();
    @(negedge clk);
    finish = 1'b1;
    pulse_change();
    collect_frame(1'b0);
    collect_frame(1'b0);
    compare_to_model(4'h7, 1'b1);
  endtask

  // Throttled en on the same GAME OVER frame
  task automatic test_back_pressure();
    collect_frame(1'b1);
    compare_to_model(4'h7, 1'b1);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial
  begin
    key         = 4'hF;
    finish      = 1'b0;
    change      = 1'b0;
    en          = 1'b0;
    error_count = 0;
    check_count = 0;
    lcg_state   = 32'd38830;
    test_reset_state();
    test_first_frame();
    test_repeat_frame();
    test_rerender();
    test_finish_mode();
    test_back_pressure();
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

//--- sources.f
common/disp_pkg.sv
rtl/frame_ram.sv
frame_render/frame_composer.sv
rtl/page_transposer.sv
rtl/scan_sequencer.sv
rtl/display_ram_ctrl.sv
tb/tb_clock_gen.sv
tb/tb_display_ram_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
set -o pipefail

verilator --binary --timing -f sources.f --top-module tb_display_ram_ctrl \
  && ./obj_dir/Vtb_display_ram_ctrl | tee sim.log \
  || { echo "Build or simulation error"; exit 1; }

grep -q "Test failed" sim.log && { echo "Simulation FAILED"; exit 1; } \
  || { echo "Simulation PASSED"; exit 0; }
